// ==== Bender.yml ====
# UDP echo core with its testbench
package:
  name: udp_echo

dependencies: {}

sources:
  # Shared definitions come first
  - udp_echo_pkg.sv
  - stream_fifo.sv
  - udp_port_filter.sv
  - led_frame_monitor.sv
  - udp_echo_core.sv

  # Simulation only
  - target: test
    files:
      - tb_udp_echo.sv

# Simulation top is tb_udp_echo, design top is udp_echo_core

// ==== build.f ====
udp_echo_pkg.sv
stream_fifo.sv
udp_port_filter.sv
led_frame_monitor.sv
udp_echo_core.sv
tb_udp_echo.sv

// ==== led_frame_monitor.sv ====
/*
 * LED frame monitor
 *
 * Watches the outgoing payload stream and shows the low byte of the
 * first beat of every frame on the LEDs.
 */
`timescale 1ns/1ps

module led_frame_monitor (
    input  logic                        clk,
    input  logic                        rst,
    input  udp_echo_pkg::payload_beat_t beat,
    input  logic                        beat_valid,
    input  logic                        beat_ready,
    output logic [7:0]                  led
);

    logic sof;
    logic xfer;

    assign xfer = beat_valid && beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            sof <= 1'b1;
            led <= 8'h00;
        end else if (xfer) begin
            // Frame starts again after every last beat
            sof <= beat.last;
            if (sof) begin
                led <= beat.data[7:0];
            end
        end
    end

endmodule

// ==== stream_fifo.sv ====
/*
 * Stream FIFO
 *
 * Circular buffer between two valid/ready streams. The entry type is a
 * parameter so the same queue holds reply headers or payload beats.
 * Accepts a push and a pop in the same cycle; ready drops at DEPTH.
 */
`timescale 1ns/1ps

module stream_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,

    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,

    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Occupancy holds when both happen together
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== tb_udp_echo.sv ====
/*
 * UDP echo core testbench
 *
 * Directed tests that send header and payload frames into the core,
 * collect the reply headers and beats, and compare them with replies
 * built from the echo rules. The LED byte is checked on every frame start.
 */
`timescale 1ns/1ps

module tb_udp_echo;

    localparam int        CLK_PERIOD  = 10;
    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam int        STALL_LIMIT = 1000;
    localparam int        DRAIN_LIMIT = 4000;
    // Tests 2, 3 and at most six beats for each frame of test 4
    localparam int        MAX_BEATS   = 5 + 4 + 3 + 8 * 6;
    localparam int        WATCHDOG_CYCLES = MAX_BEATS * 200 + 2000;

    logic clk;
    logic rst;

    udp_echo_pkg::udp_rx_hdr_t    rx_hdr;
    logic                         rx_hdr_valid;
    logic                         rx_hdr_ready;
    udp_echo_pkg::payload_beat_t  rx_payload;
    logic                         rx_payload_valid;
    logic                         rx_payload_ready;
    udp_echo_pkg::udp_reply_hdr_t tx_hdr;
    logic                         tx_hdr_valid;
    logic                         tx_hdr_ready;
    udp_echo_pkg::payload_beat_t  tx_payload;
    logic                         tx_payload_valid;
    logic                         tx_payload_ready;
    logic [7:0]                   led;

    udp_echo_pkg::udp_reply_hdr_t exp_hdrs[$];
    udp_echo_pkg::udp_reply_hdr_t got_hdrs[$];
    udp_echo_pkg::payload_beat_t  exp_beats[$];
    udp_echo_pkg::payload_beat_t  got_beats[$];

    int         errors = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         beats_accepted = 0;
    int         led_checks = 0;
    logic       rand_ready = 1'b0;
    logic       out_sof;
    logic       led_pending;
    logic [7:0] led_exp;
    logic [7:0] last_first_byte = 8'h00;

    udp_echo_core #(
        .ECHO_PORT     (ECHO_PORT),
        .LOCAL_IP      (LOCAL_IP),
        .HDR_DEPTH     (4),
        .PAYLOAD_DEPTH (64)
    ) DUT (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    // Output ready is held high or toggled at random
    always @(posedge clk) begin
        #1;
        if (rand_ready) begin
            tx_hdr_ready     = 1'($urandom % 2);
            tx_payload_ready = 1'($urandom % 2);
        end else begin
            tx_hdr_ready     = 1'b1;
            tx_payload_ready = 1'b1;
        end
    end

    // Outputs are collected at the falling edge where valid and ready are settled
    always @(negedge clk) begin
        if (rst) begin
            out_sof     = 1'b1;
            led_pending = 1'b0;
        end else begin
            if (led_pending) begin
                check_value("led", led_exp, led);
                led_pending = 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                got_hdrs.push_back(tx_hdr);
            end
            if (tx_payload_valid && tx_payload_ready) begin
                // LED expectation comes from the expected beat at this position
                if (got_beats.size() < exp_beats.size()) begin
                    if (out_sof) begin
                        led_exp     = exp_beats[got_beats.size()].data[7:0];
                        led_pending = 1'b1;
                        led_checks++;
                    end
                    out_sof = exp_beats[got_beats.size()].last;
                end
                got_beats.push_back(tx_payload);
            end
        end
    end

    task automatic check_value(input string name, input logic [135:0] exp,
                               input logic [135:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_hdr(input udp_echo_pkg::udp_rx_hdr_t h);
        int waited;
        waited       = 0;
        rx_hdr       = h;
        rx_hdr_valid = 1'b1;
        @(negedge clk);
        while (!rx_hdr_ready && waited < STALL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (rx_hdr_ready) else begin
            $display("Header was never accepted on rx_hdr");
            errors++;
        end
        @(posedge clk);
        #1;
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input udp_echo_pkg::payload_beat_t b);
        int   waited;
        logic taken;
        waited           = 0;
        rx_payload       = b;
        rx_payload_valid = 1'b1;
        @(negedge clk);
        while (!rx_payload_ready && waited < STALL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        taken = rx_payload_ready;
        assert (taken) else begin
            $display("Payload beat was never accepted on rx_payload");
            errors++;
        end
        @(posedge clk);
        #1;
        rx_payload_valid = 1'b0;
        if (taken) begin
            beats_accepted++;
        end
    endtask

    // One frame in, with its reply queued as expected if the port matches
    task automatic send_frame(input logic [15:0] port, input int nbeats);
        udp_echo_pkg::udp_rx_hdr_t    h;
        udp_echo_pkg::udp_reply_hdr_t r;
        udp_echo_pkg::payload_beat_t  b;
        h.source_ip   = $urandom;
        h.dest_ip     = LOCAL_IP;
        h.source_port = 16'(1024 + $urandom % 60000);
        h.dest_port   = port;
        h.length      = 16'(8 + 8 * nbeats);
        if (port == ECHO_PORT) begin
            r.ttl         = 8'd64;
            r.source_ip   = LOCAL_IP;
            r.dest_ip     = h.source_ip;
            r.source_port = h.dest_port;
            r.dest_port   = h.source_port;
            r.length      = h.length;
            r.checksum    = 16'h0000;
            exp_hdrs.push_back(r);
        end
        send_hdr(h);
        for (int i = 0; i < nbeats; i++) begin
            b.data = {$urandom, $urandom};
            b.keep = (i == nbeats - 1) ? (8'hFF >> ($urandom % 8)) : 8'hFF;
            b.last = (i == nbeats - 1);
            b.user = 1'($urandom % 2);
            if (port == ECHO_PORT) begin
                exp_beats.push_back(b);
                if (i == 0) begin
                    last_first_byte = b.data[7:0];
                end
            end
            send_beat(b);
        end
    endtask

    task automatic collect_and_check();
        int waited;
        int n;
        waited = 0;
        while ((got_hdrs.size() < exp_hdrs.size() || got_beats.size() < exp_beats.size())
               && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (waited < DRAIN_LIMIT) else begin
            $display("Timed out waiting for the echoed frames");
            errors++;
        end
        // Extra cycles so that a surplus reply would show up
        repeat (20) @(posedge clk);
        #1;
        check_value("tx_hdr count", exp_hdrs.size(), got_hdrs.size());
        check_value("tx_payload count", exp_beats.size(), got_beats.size());
        n = (got_hdrs.size() < exp_hdrs.size()) ? got_hdrs.size() : exp_hdrs.size();
        for (int i = 0; i < n; i++) begin
            check_value("tx_hdr.ttl", exp_hdrs[i].ttl, got_hdrs[i].ttl);
            check_value("tx_hdr.source_ip", exp_hdrs[i].source_ip, got_hdrs[i].source_ip);
            check_value("tx_hdr.dest_ip", exp_hdrs[i].dest_ip, got_hdrs[i].dest_ip);
            check_value("tx_hdr.source_port", exp_hdrs[i].source_port,
                        got_hdrs[i].source_port);
            check_value("tx_hdr.dest_port", exp_hdrs[i].dest_port, got_hdrs[i].dest_port);
            check_value("tx_hdr.length", exp_hdrs[i].length, got_hdrs[i].length);
            check_value("tx_hdr.checksum", exp_hdrs[i].checksum, got_hdrs[i].checksum);
        end
        n = (got_beats.size() < exp_beats.size()) ? got_beats.size() : exp_beats.size();
        for (int i = 0; i < n; i++) begin
            check_value("tx_payload.data", exp_beats[i].data, got_beats[i].data);
            check_value("tx_payload.keep", exp_beats[i].keep, got_beats[i].keep);
            check_value("tx_payload.last", exp_beats[i].last, got_beats[i].last);
            check_value("tx_payload.user", exp_beats[i].user, got_beats[i].user);
        end
        exp_hdrs.delete();
        got_hdrs.delete();
        exp_beats.delete();
        got_beats.delete();
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic reset_state();
        int start_errors;
        start_errors = errors;
        check_value("tx_hdr_valid", 1'b0, tx_hdr_valid);
        check_value("tx_payload_valid", 1'b0, tx_payload_valid);
        check_value("led", 8'h00, led);
        check_value("rx_payload_ready", 1'b0, rx_payload_ready);
        finish_test("reset_state", start_errors);
    endtask

    task automatic single_echo();
        int start_errors;
        start_errors = errors;
        send_frame(ECHO_PORT, 5);
        collect_and_check();
        finish_test("single_echo", start_errors);
    endtask

    task automatic drop_then_echo();
        int start_errors;
        int start_beats;
        start_errors = errors;
        start_beats  = beats_accepted;
        send_frame(16'd80, 4);
        send_frame(ECHO_PORT, 3);
        collect_and_check();
        check_value("rx_payload transfers", 7, beats_accepted - start_beats);
        finish_test("drop_then_echo", start_errors);
    endtask

    task automatic mixed_backpressure();
        int start_errors;
        start_errors = errors;
        rand_ready   = 1'b1;
        for (int i = 0; i < 8; i++) begin
            // Frames 1, 4 and 7 go to another port
            send_frame((i % 3 == 1) ? 16'(5000 + i) : ECHO_PORT, 1 + $urandom % 6);
        end
        collect_and_check();
        rand_ready = 1'b0;
        finish_test("mixed_backpressure", start_errors);
    endtask

    task automatic led_final();
        int start_errors;
        start_errors = errors;
        assert (led_checks > 0) else begin
            $display("No LED update was seen on any echoed frame");
            errors++;
        end
        check_value("led", last_first_byte, led);
        finish_test("led_final", start_errors);
    endtask

    initial begin
        void'($urandom(32'h38ed902e));
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        reset_state();
        single_echo();
        drop_then_echo();
        mixed_backpressure();
        led_final();
        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== udp_echo_core.sv ====
/*
 * UDP echo core
 *
 * Top level of the echo path. Frames for the echo port come back as a
 * reply header and an unchanged payload, each through its own queue so
 * several frames can be in flight. Other frames are discarded.
 */
`timescale 1ns/1ps

module udp_echo_core #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT     = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP      = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter int                      HDR_DEPTH     = 4,
    parameter int                      PAYLOAD_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         rst,

    // Frames from the UDP stack
    input  udp_echo_pkg::udp_rx_hdr_t    rx_hdr,
    input  logic                         rx_hdr_valid,
    output logic                         rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t  rx_payload,
    input  logic                         rx_payload_valid,
    output logic                         rx_payload_ready,

    // Replies to the UDP stack
    output udp_echo_pkg::udp_reply_hdr_t tx_hdr,
    output logic                         tx_hdr_valid,
    input  logic                         tx_hdr_ready,
    output udp_echo_pkg::payload_beat_t  tx_payload,
    output logic                         tx_payload_valid,
    input  logic                         tx_payload_ready,

    output logic [7:0]                   led
);

    udp_echo_pkg::udp_reply_hdr_t reply_hdr;
    logic                         reply_hdr_valid;
    logic                         reply_hdr_ready;

    udp_echo_pkg::payload_beat_t  echo_beat;
    logic                         echo_beat_valid;
    logic                         echo_beat_ready;

    udp_port_filter #(
        .ECHO_PORT (ECHO_PORT),
        .LOCAL_IP  (LOCAL_IP)
    ) filter (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .reply_hdr        (reply_hdr),
        .reply_hdr_valid  (reply_hdr_valid),
        .reply_hdr_ready  (reply_hdr_ready),
        .echo_beat        (echo_beat),
        .echo_beat_valid  (echo_beat_valid),
        .echo_beat_ready  (echo_beat_ready)
    );

    // Short queue, one entry per frame in flight
    stream_fifo #(
        .T     (udp_echo_pkg::udp_reply_hdr_t),
        .DEPTH (HDR_DEPTH)
    ) hdr_queue (
        .clk       (clk),
        .rst       (rst),
        .in_data   (reply_hdr),
        .in_valid  (reply_hdr_valid),
        .in_ready  (reply_hdr_ready),
        .out_data  (tx_hdr),
        .out_valid (tx_hdr_valid),
        .out_ready (tx_hdr_ready)
    );

    stream_fifo #(
        .T     (udp_echo_pkg::payload_beat_t),
        .DEPTH (PAYLOAD_DEPTH)
    ) payload_queue (
        .clk       (clk),
        .rst       (rst),
        .in_data   (echo_beat),
        .in_valid  (echo_beat_valid),
        .in_ready  (echo_beat_ready),
        .out_data  (tx_payload),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready)
    );

    led_frame_monitor led_monitor (
        .clk        (clk),
        .rst        (rst),
        .beat       (tx_payload),
        .beat_valid (tx_payload_valid),
        .beat_ready (tx_payload_ready),
        .led        (led)
    );

endmodule

// ==== udp_echo_pkg.sv ====
/*
 * UDP echo shared definitions
 *
 * Beat and header widths, the received and reply header layouts, the
 * payload beat layout and the default echo configuration. The payload
 * beat mirrors a 64-bit stream with byte enables, an end-of-frame flag
 * and a one-bit error or user flag.
 */
package udp_echo_pkg;

    // Payload stream geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Header as delivered by the upstream UDP stack
    typedef struct packed {
        ip_addr_t  source_ip;
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        logic [15:0] length;
    } udp_rx_hdr_t;

    // Header handed to the transmit side of the stack
    typedef struct packed {
        logic [7:0]  ttl;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_reply_hdr_t;

    // One payload beat, the same on the receive and transmit side
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              user;
    } payload_beat_t;

    // Every reply leaves with this hop limit
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Port that is answered, everything else is discarded
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // 192.168.1.128
    localparam ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

endpackage

// ==== udp_port_filter.sv ====
/*
 * UDP port filter
 *
 * Takes one header and then the payload of each received frame. A frame
 * for the echo port produces a reply header with swapped ports, addressed
 * back to the sender, and its beats are forwarded. Any other frame is
 * accepted and thrown away up to its last beat.
 */
`timescale 1ns/1ps

module udp_port_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP  = udp_echo_pkg::DEFAULT_LOCAL_IP
) (
    input  logic                        clk,
    input  logic                        rst,

    // Received frame
    input  udp_echo_pkg::udp_rx_hdr_t   rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t rx_payload,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,

    // Toward the header queue
    output udp_echo_pkg::udp_reply_hdr_t reply_hdr,
    output logic                         reply_hdr_valid,
    input  logic                         reply_hdr_ready,

    // Toward the payload queue
    output udp_echo_pkg::payload_beat_t echo_beat,
    output logic                        echo_beat_valid,
    input  logic                        echo_beat_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ECHO,
        ST_DROP
    } state_t;

    state_t state;

    logic port_match;
    logic hdr_xfer;
    logic beat_xfer;

    // Decision is made once per frame, while the header is presented
    assign port_match = (rx_hdr.dest_port == ECHO_PORT);

    // Reply header is formed straight from the received one
    always_comb begin
        reply_hdr.ttl         = udp_echo_pkg::REPLY_TTL;
        reply_hdr.source_ip   = LOCAL_IP;
        reply_hdr.dest_ip     = rx_hdr.source_ip;
        reply_hdr.source_port = rx_hdr.dest_port;
        reply_hdr.dest_port   = rx_hdr.source_port;
        reply_hdr.length      = rx_hdr.length;
        reply_hdr.checksum    = 16'h0000;
    end

    // A drop needs no room downstream, a match waits for the header queue
    always_comb begin
        rx_hdr_ready    = 1'b0;
        reply_hdr_valid = 1'b0;
        if (state == ST_IDLE) begin
            rx_hdr_ready    = port_match ? reply_hdr_ready : 1'b1;
            reply_hdr_valid = rx_hdr_valid && port_match;
        end
    end

    assign echo_beat = rx_payload;

    always_comb begin
        case (state)
            ST_ECHO: begin
                rx_payload_ready = echo_beat_ready;
                echo_beat_valid  = rx_payload_valid;
            end
            ST_DROP: begin
                // Sink everything until the frame ends
                rx_payload_ready = 1'b1;
                echo_beat_valid  = 1'b0;
            end
            default: begin
                rx_payload_ready = 1'b0;
                echo_beat_valid  = 1'b0;
            end
        endcase
    end

    assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
    assign beat_xfer = rx_payload_valid && rx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? ST_ECHO : ST_DROP;
                    end
                end
                ST_ECHO, ST_DROP: begin
                    // Next header only after the last beat is gone
                    if (beat_xfer && rx_payload.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule
